// ==== src.f ====
hub_pkg.sv
frame_fifo.sv
gap_timer.sv
hub_arbiter.sv
hub_tx_stage.sv
frame_hub.sv
tb_frame_hub.sv

// ==== tb_frame_hub.sv ====
`timescale 1ns/1ps

module tb_frame_hub;
  import hub_pkg::*;

  localparam int MAXN            = 20;
  localparam int TOTAL_FRAMES    = 78;
  localparam int WATCHDOG_CYCLES = TOTAL_FRAMES * (MAX_FRAME + IFG + 4) * NPORTS + 200;
  localparam int DRAIN_LIMIT     = 4 * (IFG + 4);

  typedef logic [MAX_FRAME-1:0][7:0] frame_data_t;

  typedef struct packed {
    port_idx_t   port;
    logic [5:0]  len;
    frame_data_t dat;
  } frame_rec_t;

  logic              clk = 1'b0;
  logic              rst;
  logic [NPORTS-1:0] in_val;
  byte_t             in_dat [NPORTS];
  logic [NPORTS-1:0] ready;
  hub_beat_t         out_beat;

  logic [31:0]  lfsr = 32'h8b1d7c2d;
  frame_rec_t   exp_q [$];
  port_idx_t    got_ports [$];
  int           sched_n [NPORTS];
  int           sched_len [NPORTS][MAXN];
  int           sched_gap [NPORTS][MAXN];
  frame_data_t  sched_dat [NPORTS][MAXN];
  int           errors = 0;
  int           checks = 0;
  int           frames_seen = 0;
  logic         ready_fell = 1'b0;
  logic         in_frame = 1'b0;
  logic         have_prev = 1'b0;
  int           idle_cnt = 0;
  frame_rec_t   got;

  frame_hub dut (
    .clk    (clk),
    .rst    (rst),
    .in_val (in_val),
    .in_dat (in_dat),
    .ready  (ready),
    .out    (out_beat)
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // random source and reference model
  ////////////////////////////////////////////////////////////

  function automatic logic lfsr_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ 32'h80200003;
    return b;
  endfunction

  function automatic int rand_bits(int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) v = (v << 1) | int'(lfsr_bit());
    return v;
  endfunction

  // only the first len bytes belong to the frame
  function automatic frame_rec_t expect_frame(port_idx_t port, int len, frame_data_t dat);
    frame_rec_t r;
    r.port = port;
    r.len  = 6'(len);
    r.dat  = '0;
    for (int i = 0; i < len; i++) r.dat[i] = dat[i];
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // stations
  ////////////////////////////////////////////////////////////

  task automatic plan_port(int p, int n, int len);
    for (int k = 0; k < n; k++) begin
      sched_len[p][k] = (len == 0) ? 2 + rand_bits(5) % (MAX_FRAME - 1) : len;
      sched_gap[p][k] = (len == 0) ? rand_bits(3) : 0;
      for (int i = 0; i < MAX_FRAME; i++) sched_dat[p][k][i] = byte_t'(rand_bits(8));
    end
    sched_n[p] = n;
  endtask

  task automatic send_frame(int p, int len, frame_data_t dat);
    // no frame starts while the queue may overflow
    while (!ready[p]) begin
      @(posedge clk);
      #1;
    end
    exp_q.push_back(expect_frame(port_idx_t'(p), len, dat));
    for (int i = 0; i < len; i++) begin
      in_val[p] = 1'b1;
      in_dat[p] = dat[i];
      @(posedge clk);
      #1;
    end
    in_val[p] = 1'b0;
    in_dat[p] = '0;
    @(posedge clk);
    #1;
  endtask

  task automatic run_station(int p);
    for (int k = 0; k < sched_n[p]; k++) begin
      send_frame(p, sched_len[p][k], sched_dat[p][k]);
      repeat (sched_gap[p][k]) begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  task automatic run_all();
    fork
      run_station(0);
      run_station(1);
      run_station(2);
    join
  endtask

  task automatic clear_plan();
    for (int p = 0; p < NPORTS; p++) sched_n[p] = 0;
    got_ports.delete();
  endtask

  task automatic do_reset();
    rst    = 1'b1;
    in_val = '0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
  endtask

  // give up once the output has been idle too long
  task automatic wait_drain();
    int stall;
    stall = 0;
    while ((exp_q.size() != 0 || in_frame) && stall < DRAIN_LIMIT) begin
      @(posedge clk);
      #1;
      if (out_beat.val) begin
        stall = 0;
      end else begin
        stall++;
      end
    end
    repeat (IFG + 4) @(posedge clk);
    #1;
    checks++;
    if (exp_q.size() != 0) begin
      errors++;
      $display("error %0t: %0d frames never delivered", $time, exp_q.size());
      exp_q.delete();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // scoreboard
  ////////////////////////////////////////////////////////////

  task automatic match_frame(frame_rec_t f);
    int idx;
    idx = -1;
    for (int i = 0; i < exp_q.size(); i++) begin
      if (idx < 0 && exp_q[i].port == f.port) idx = i;
    end
    checks++;
    frames_seen++;
    if (idx < 0) begin
      errors++;
      $display("error %0t: unexpected frame from port %0d", $time, f.port);
    end else begin
      if (f.len != exp_q[idx].len) begin
        errors++;
        $display("error %0t: port %0d length %0d, expected %0d",
                 $time, f.port, f.len, exp_q[idx].len);
      end else if (f.dat != exp_q[idx].dat) begin
        errors++;
        $display("error %0t: port %0d payload mismatch", $time, f.port);
      end
      exp_q.delete(idx);
      got_ports.push_back(f.port);
    end
  endtask

  // sampled on the falling edge, away from the register updates
  always @(negedge clk) begin
    if (rst) begin
      in_frame  = 1'b0;
      have_prev = 1'b0;
      idle_cnt  = 0;
    end else begin
      if (!ready[0]) ready_fell = 1'b1;
      if (out_beat.val) begin
        if (!in_frame) begin
          checks++;
          if (have_prev && idle_cnt < IFG) begin
            errors++;
            $display("error %0t: gap of %0d idle cycles before frame", $time, idle_cnt);
          end
          in_frame = 1'b1;
          got.port = out_beat.port;
          got.len  = '0;
          got.dat  = '0;
        end else if (out_beat.port != got.port) begin
          errors++;
          $display("error %0t: port changed inside a frame", $time);
        end
        if (got.len < MAX_FRAME) begin
          got.dat[got.len] = out_beat.dat;
          got.len = got.len + 1'b1;
        end else begin
          errors++;
          $display("error %0t: frame longer than %0d bytes", $time, MAX_FRAME);
        end
        if (out_beat.last) begin
          match_frame(got);
          in_frame  = 1'b0;
          have_prev = 1'b1;
          idle_cnt  = 0;
        end
      end else begin
        if (in_frame) begin
          errors++;
          $display("error %0t: out.val dropped inside a frame", $time);
          in_frame = 1'b0;
        end
        idle_cnt++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst    = 1'b1;
    in_val = '0;
    for (int p = 0; p < NPORTS; p++) in_dat[p] = '0;
    do_reset();
    checks++;
    if (ready !== '1 || out_beat.val !== 1'b0) begin
      errors++;
      $display("error %0t: ready %b out.val %b after reset", $time, ready, out_beat.val);
    end

    // single frame on port 1
    clear_plan();
    plan_port(1, 1, 8);
    run_all();
    wait_drain();
    checks++;
    if (got_ports.size() != 1 || got_ports[0] != 2'd1) begin
      errors++;
      $display("error %0t: single frame from port 1 not seen once", $time);
    end

    // equal frames on all ports in one cycle, pointer fresh from reset
    do_reset();
    clear_plan();
    for (int p = 0; p < NPORTS; p++) plan_port(p, 1, 6);
    run_all();
    wait_drain();
    checks++;
    if (got_ports.size() != 3 || got_ports[0] != 2'd0 || got_ports[1] != 2'd1 ||
        got_ports[2] != 2'd2) begin
      errors++;
      $display("error %0t: round robin order wrong", $time);
    end

    // long frames fill port 0
    clear_plan();
    ready_fell = 1'b0;
    plan_port(0, 6, MAX_FRAME);
    plan_port(1, 4, MAX_FRAME);
    plan_port(2, 4, MAX_FRAME);
    run_all();
    wait_drain();
    checks++;
    if (!ready_fell) begin
      errors++;
      $display("error %0t: ready on port 0 never fell", $time);
    end

    // random traffic
    clear_plan();
    for (int p = 0; p < NPORTS; p++) plan_port(p, MAXN, 0);
    run_all();
    wait_drain();

    $display("frames %0d, checks %0d, errors %0d", frames_seen, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: traffic did not drain within %0d cycles", WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== frame_hub.sv ====
`timescale 1ns/1ps

module frame_hub (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [hub_pkg::NPORTS-1:0] in_val,
  input  hub_pkg::byte_t             in_dat [hub_pkg::NPORTS],
  output logic [hub_pkg::NPORTS-1:0] ready,
  output hub_pkg::hub_beat_t         out
);
  import hub_pkg::*;

  logic [NPORTS-1:0] has_frame;
  fifo_word_t        head [NPORTS];
  logic [NPORTS-1:0] pop;
  logic              issue;
  port_idx_t         grant_port;
  fifo_word_t        word;
  logic              gap_req;
  logic              gap_ack;

  ////////////////////////////////////////////////////////////
  // per station queues
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NPORTS; i++) begin : g_port
    frame_fifo fifo_inst (
      .clk       (clk),
      .rst       (rst),
      .in_val    (in_val[i]),
      .in_dat    (in_dat[i]),
      .pop       (pop[i]),
      .ready     (ready[i]),
      .has_frame (has_frame[i]),
      .head      (head[i])
    );
  end

  hub_arbiter arb_inst (
    .clk        (clk),
    .rst        (rst),
    .has_frame  (has_frame),
    .head       (head),
    .pop        (pop),
    .issue      (issue),
    .grant_port (grant_port),
    .word       (word),
    .gap_req    (gap_req),
    .gap_ack    (gap_ack)
  );

  gap_timer gap_inst (
    .clk     (clk),
    .rst     (rst),
    .gap_req (gap_req),
    .gap_ack (gap_ack)
  );

  hub_tx_stage tx_inst (
    .clk        (clk),
    .rst        (rst),
    .issue      (issue),
    .grant_port (grant_port),
    .word       (word),
    .out        (out)
  );

endmodule

// ==== hub_tx_stage.sv ====
`timescale 1ns/1ps

module hub_tx_stage (
  input  logic                clk,
  input  logic                rst,
  input  logic                issue,
  input  hub_pkg::port_idx_t  grant_port,
  input  hub_pkg::fifo_word_t word,
  output hub_pkg::hub_beat_t  out
);
  import hub_pkg::*;

  fifo_cnt_t byte_cnt;
  logic      at_max;
  logic      end_beat;

  // cut a runaway frame at MAX_FRAME bytes
  assign at_max   = byte_cnt == fifo_cnt_t'(MAX_FRAME - 1);
  assign end_beat = word.last || at_max;

  ////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    out.port <= grant_port;
    out.dat  <= word.dat;
    out.last <= end_beat;
    if (rst) begin
      out.val  <= 1'b0;
      byte_cnt <= '0;
    end else begin
      out.val <= issue;
      if (issue) begin
        if (end_beat) begin
          byte_cnt <= '0;
        end else begin
          byte_cnt <= byte_cnt + 1'b1;
        end
      end
    end
  end

endmodule

// ==== hub_arbiter.sv ====
`timescale 1ns/1ps

module hub_arbiter (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [hub_pkg::NPORTS-1:0]  has_frame,
  input  hub_pkg::fifo_word_t         head [hub_pkg::NPORTS],
  output logic [hub_pkg::NPORTS-1:0]  pop,
  output logic                        issue,
  output hub_pkg::port_idx_t          grant_port,
  output hub_pkg::fifo_word_t         word,
  output logic                        gap_req,
  input  logic                        gap_ack
);
  import hub_pkg::*;

  arb_state_t state;
  port_idx_t  last_port;
  port_idx_t  pick;
  port_idx_t  cand;
  logic       found;

  ////////////////////////////////////////////////////////////
  // round robin search
  ////////////////////////////////////////////////////////////

  // start one past the last served port
  always_comb begin
    found = 1'b0;
    pick  = last_port;
    cand  = last_port;
    for (int k = 1; k <= NPORTS; k++) begin
      cand = port_idx_t'((int'(last_port) + k) % NPORTS);
      if (!found && has_frame[cand]) begin
        found = 1'b1;
        pick  = cand;
      end
    end
  end

  always_comb begin
    issue = (state == ARB_SEND);
    word  = head[grant_port];
    pop   = '0;
    if (issue) begin
      pop[grant_port] = 1'b1;
    end
  end

  assign gap_req = (state == ARB_GAP_REQ);

  ////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ARB_IDLE;
      last_port  <= port_idx_t'(NPORTS - 1);
      grant_port <= '0;
    end else begin
      case (state)
        ARB_IDLE: begin
          if (found) begin
            grant_port <= pick;
            state      <= ARB_SEND;
          end
        end
        ARB_SEND: begin
          // whole frame is queued, so no bubbles
          if (word.last) begin
            last_port <= grant_port;
            state     <= ARB_GAP_REQ;
          end
        end
        ARB_GAP_REQ: begin
          if (gap_ack) state <= ARB_GAP_REL;
        end
        ARB_GAP_REL: begin
          if (!gap_ack) state <= ARB_IDLE;
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

endmodule

// ==== gap_timer.sv ====
`timescale 1ns/1ps

module gap_timer (
  input  logic clk,
  input  logic rst,
  input  logic gap_req,
  output logic gap_ack
);
  import hub_pkg::*;

  logic     req_d;
  logic     busy;
  gap_cnt_t cnt;

  // load on req rise, ack lands IFG cycles later
  always_ff @(posedge clk) begin
    if (rst) begin
      req_d   <= 1'b0;
      busy    <= 1'b0;
      cnt     <= '0;
      gap_ack <= 1'b0;
    end else begin
      req_d <= gap_req;
      if (gap_req && !req_d && !gap_ack) begin
        busy <= 1'b1;
        cnt  <= gap_cnt_t'(IFG - 1);
      end else if (busy) begin
        cnt <= cnt - 1'b1;
        if (cnt == gap_cnt_t'(1)) begin
          busy    <= 1'b0;
          gap_ack <= 1'b1;
        end
      end
      // release phase of the handshake
      if (gap_ack && !gap_req) begin
        gap_ack <= 1'b0;
      end
    end
  end

endmodule

// ==== frame_fifo.sv ====
`timescale 1ns/1ps

module frame_fifo (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_val,
  input  hub_pkg::byte_t      in_dat,
  input  logic                pop,
  output logic                ready,
  output logic                has_frame,
  output hub_pkg::fifo_word_t head
);
  import hub_pkg::*;

  logic       hold_val;
  byte_t      hold_dat;
  logic       wr_en;
  fifo_word_t wr_word;
  fifo_word_t mem [2**FIFO_AW];
  fifo_addr_t wr_ptr;
  fifo_addr_t rd_ptr;
  fifo_cnt_t  used;
  fifo_cnt_t  free_words;
  fifo_cnt_t  frames;

  // byte held one cycle so its last flag is known
  always_ff @(posedge clk) begin
    hold_dat <= in_dat;
    if (rst) begin
      hold_val <= 1'b0;
    end else begin
      hold_val <= in_val;
    end
  end

  assign wr_en        = hold_val;
  assign wr_word.last = !in_val;
  assign wr_word.dat  = hold_dat;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_word;
    end
  end

  assign head = mem[rd_ptr];

  ////////////////////////////////////////////////////////////
  // pointers and counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      used   <= '0;
      frames <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, pop})
        2'b10:   used <= used + 1'b1;
        2'b01:   used <= used - 1'b1;
        default: used <= used;
      endcase
      // complete frames only
      case ({wr_en && wr_word.last, pop && head.last})
        2'b10:   frames <= frames + 1'b1;
        2'b01:   frames <= frames - 1'b1;
        default: frames <= frames;
      endcase
    end
  end

  assign free_words = fifo_cnt_t'(2 ** FIFO_AW) - used;
  assign ready      = free_words >= fifo_cnt_t'(MAX_FRAME);
  assign has_frame  = frames != '0;

endmodule

// ==== hub_pkg.sv ====
package hub_pkg;

  ////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////

  localparam int NPORTS    = 3;
  localparam int FIFO_AW   = 6;
  localparam int MAX_FRAME = 24;
  localparam int IFG       = 10;

  typedef logic [7:0]         byte_t;
  typedef logic [1:0]         port_idx_t;
  typedef logic [FIFO_AW-1:0] fifo_addr_t;
  typedef logic [FIFO_AW:0]   fifo_cnt_t;
  typedef logic [3:0]         gap_cnt_t;

  ////////////////////////////////////////////////////////////
  // stream words
  ////////////////////////////////////////////////////////////

  // one queued byte, last marks end of frame
  typedef struct packed {
    logic  last;
    byte_t dat;
  } fifo_word_t;

  typedef struct packed {
    logic      val;
    logic      last;
    port_idx_t port;
    byte_t     dat;
  } hub_beat_t;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_SEND,
    ARB_GAP_REQ,
    ARB_GAP_REL
  } arb_state_t;

endpackage
